//--- Bender.yml
package:
  name: basic_organ

sources:
  - files:
      - logic/organ_pkg.sv
      - logic/scope_ctrl_pkg.sv
      - logic/ms_timebase.sv
      - logic/tone_gen.sv
      - logic/key_repeat.sv
      - logic/scope_speed_reg.sv
      - logic/hex_display.sv
      - logic/basic_organ.sv
  - target: test
    files:
      - verification/basic_organ_tb.sv

//--- basic_organ.f
logic/organ_pkg.sv
logic/scope_ctrl_pkg.sv
logic/ms_timebase.sv
logic/tone_gen.sv
logic/key_repeat.sv
logic/scope_speed_reg.sv
logic/hex_display.sv
logic/basic_organ.sv
verification/basic_organ_tb.sv

//--- logic/basic_organ.sv
`timescale 1ns/1ps

module basic_organ #(
  parameter int tick_div = scope_ctrl_pkg::TICK_DIV_DEFAULT
) (
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  logic [2:0]  key_n,
  input  logic [2:0]  note_sel,
  input  logic        tone_en,
  output logic [7:0]  audio_sample,
  output logic [15:0] scope_period,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  logic                       tick;
  scope_ctrl_pkg::speed_cmd_e cmd;
  logic [scope_ctrl_pkg::NUM_DIGITS-1:0][scope_ctrl_pkg::SEG_W-1:0] hex;

  // ==============================
  // Tone path
  // ==============================

  tone_gen u_tone_gen (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note_sel     (note_sel),
    .tone_en      (tone_en),
    .audio_sample (audio_sample)
  );

  // ==============================
  // Scope speed and display
  // ==============================

  ms_timebase #(
    .tick_div (tick_div)
  ) u_ms_timebase (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (tick)
  );

  key_repeat u_key_repeat (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (tick),
    .key_n   (key_n),
    .cmd     (cmd)
  );

  scope_speed_reg u_scope_speed_reg (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .period  (scope_period)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (tick),
    .period  (scope_period),
    .hex     (hex)
  );

  // One port per digit
  assign hex0 = hex[0];
  assign hex1 = hex[1];
  assign hex2 = hex[2];
  assign hex3 = hex[3];
  assign hex4 = hex[4];
  assign hex5 = hex[5];

endmodule

//--- logic/hex_display.sv
`timescale 1ns/1ps

module hex_display (
  input  logic                                CLK_50M,
  input  logic                                rst_n,
  input  logic                                tick,
  input  logic [scope_ctrl_pkg::PERIOD_W-1:0] period,
  output logic [scope_ctrl_pkg::NUM_DIGITS-1:0][scope_ctrl_pkg::SEG_W-1:0] hex
);

  logic [scope_ctrl_pkg::REFRESH_CNT_W-1:0]                          refresh_cnt;
  logic                                                             refresh;
  logic [scope_ctrl_pkg::NUM_DIGITS*scope_ctrl_pkg::NIBBLE_W-1:0] shown;

  // Active-low segments, bit 6 is segment g
  function automatic logic [scope_ctrl_pkg::SEG_W-1:0] glyph(
    input logic [scope_ctrl_pkg::NIBBLE_W-1:0] nib
  );
    logic [scope_ctrl_pkg::SEG_W-1:0] seg;
    case (nib)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // ==============================
  // Refresh interval
  // ==============================

  assign refresh = tick && (refresh_cnt == scope_ctrl_pkg::REFRESH_LAST);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      shown       <= '0;
    end
    else
    begin
      if (refresh)
        refresh_cnt <= '0;
      else if (tick)
        refresh_cnt <= refresh_cnt + 1'b1;
      // Zero-extended, upper two digits stay 0
      if (refresh)
        shown <= {{(scope_ctrl_pkg::NUM_DIGITS * scope_ctrl_pkg::NIBBLE_W
                    - scope_ctrl_pkg::PERIOD_W){1'b0}}, period};
    end
  end

  // Decoded digits, digit 0 least significant
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < scope_ctrl_pkg::NUM_DIGITS; i++)
        hex[i] <= glyph('0);
    end
    else
    begin
      for (int i = 0; i < scope_ctrl_pkg::NUM_DIGITS; i++)
        hex[i] <= glyph(shown[i*scope_ctrl_pkg::NIBBLE_W +: scope_ctrl_pkg::NIBBLE_W]);
    end
  end

endmodule

//--- logic/key_repeat.sv
`timescale 1ns/1ps

module key_repeat (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic                       tick,
  input  logic [2:0]                 key_n,
  output scope_ctrl_pkg::speed_cmd_e cmd
);

  // Keys after inversion, 1 means pressed
  logic [2:0] key_meta;
  logic [2:0] key_sync;

  logic [scope_ctrl_pkg::REPEAT_CNT_W-1:0] win_cnt;
  logic                                    window_end;

  // ==============================
  // Key synchronisers
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
    end
  end

  // ==============================
  // Repeat window
  // ==============================

  assign window_end = tick && (win_cnt == scope_ctrl_pkg::REPEAT_LAST);

  // Free running, counted in ticks
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      win_cnt <= '0;
    else if (window_end)
      win_cnt <= '0;
    else if (tick)
      win_cnt <= win_cnt + 1'b1;
  end

  // Reset key wins every cycle; up before down at the window end
  always_comb
  begin
    if (key_sync[scope_ctrl_pkg::KEY_RESET])
      cmd = scope_ctrl_pkg::CMD_RESET;
    else if (window_end && key_sync[scope_ctrl_pkg::KEY_UP])
      cmd = scope_ctrl_pkg::CMD_UP;
    else if (window_end && key_sync[scope_ctrl_pkg::KEY_DOWN])
      cmd = scope_ctrl_pkg::CMD_DOWN;
    else
      cmd = scope_ctrl_pkg::CMD_NONE;
  end

endmodule

//--- logic/ms_timebase.sv
`timescale 1ns/1ps

module ms_timebase #(
  parameter int tick_div = scope_ctrl_pkg::TICK_DIV_DEFAULT
) (
  input  logic CLK_50M,
  input  logic rst_n,
  output logic tick
);

  localparam int CNT_W = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [CNT_W-1:0] cycle_cnt;

  // Wrapping counter, one strobe per wrap
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cycle_cnt <= '0;
      tick      <= 1'b0;
    end
    else if (cycle_cnt == CNT_W'(tick_div - 1))
    begin
      cycle_cnt <= '0;
      tick      <= 1'b1;
    end
    else
    begin
      cycle_cnt <= cycle_cnt + 1'b1;
      tick      <= 1'b0;
    end
  end

endmodule

//--- logic/organ_pkg.sv
package organ_pkg;

  // ==============================
  // Note selection
  // ==============================

  // Switch code 0 is the lowest note
  typedef enum logic [2:0] {
    C5 = 3'd0,
    D5 = 3'd1,
    E5 = 3'd2,
    F5 = 3'd3,
    G5 = 3'd4,
    A5 = 3'd5,
    B5 = 3'd6,
    C6 = 3'd7
  } note_e;

  localparam int NUM_NOTES = 8;
  localparam int HALF_PERIOD_W = 32;

  // Half period per note, in 50 MHz clock cycles
  localparam logic [HALF_PERIOD_W-1:0] NOTE_HALF_PERIOD [NUM_NOTES] = '{
    32'd47801,
    32'd42589,
    32'd37936,
    32'd35817,
    32'd31928,
    32'd28409,
    32'd25329,
    32'd23901
  };

  // ==============================
  // Audio sample
  // ==============================

  localparam int SAMPLE_W = 8;

  // Signed full-scale levels of the square wave
  localparam logic [SAMPLE_W-1:0] SAMPLE_HIGH = 8'h7F;
  localparam logic [SAMPLE_W-1:0] SAMPLE_LOW  = 8'h80;

  // Silence while the tone is off
  localparam logic [SAMPLE_W-1:0] SAMPLE_ZERO = 8'h00;

endpackage

//--- logic/scope_ctrl_pkg.sv
package scope_ctrl_pkg;

  // ==============================
  // Speed commands
  // ==============================

  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_UP    = 2'd1,
    CMD_DOWN  = 2'd2,
    CMD_RESET = 2'd3
  } speed_cmd_e;

  // Bit positions in the active-low key bus
  localparam int KEY_UP    = 0;
  localparam int KEY_DOWN  = 1;
  localparam int KEY_RESET = 2;

  // ==============================
  // Sampling period
  // ==============================

  localparam int PERIOD_W = 16;
  localparam logic [PERIOD_W-1:0] DEFAULT_PERIOD = 16'd12499;

  // Signed offset, kept within plus and minus the limit
  localparam logic signed [PERIOD_W-1:0] SPEED_STEP  = 16'sd100;
  localparam logic signed [PERIOD_W-1:0] SPEED_LIMIT = 16'sd12000;

  // ==============================
  // Time base and rates
  // ==============================

  // 1 ms at 50 MHz
  localparam int TICK_DIV_DEFAULT = 50000;

  // Ten steps per second while a key is held
  localparam int REPEAT_TICKS = 100;
  localparam int REPEAT_CNT_W = $clog2(REPEAT_TICKS);
  localparam logic [REPEAT_CNT_W-1:0] REPEAT_LAST = REPEAT_CNT_W'(REPEAT_TICKS - 1);

  // Display refresh twice per second
  localparam int REFRESH_TICKS = 500;
  localparam int REFRESH_CNT_W = $clog2(REFRESH_TICKS);
  localparam logic [REFRESH_CNT_W-1:0] REFRESH_LAST = REFRESH_CNT_W'(REFRESH_TICKS - 1);

  // Seven-segment digits
  localparam int NUM_DIGITS = 6;
  localparam int NIBBLE_W = 4;
  localparam int SEG_W = 7;

endpackage

//--- logic/scope_speed_reg.sv
`timescale 1ns/1ps

module scope_speed_reg (
  input  logic                                CLK_50M,
  input  logic                                rst_n,
  input  scope_ctrl_pkg::speed_cmd_e          cmd,
  output logic [scope_ctrl_pkg::PERIOD_W-1:0] period
);

  logic signed [scope_ctrl_pkg::PERIOD_W-1:0] offset;
  logic signed [scope_ctrl_pkg::PERIOD_W-1:0] offset_up;
  logic signed [scope_ctrl_pkg::PERIOD_W-1:0] offset_dn;

  // Next offsets, clamped at the limits
  always_comb
  begin
    offset_up = offset + scope_ctrl_pkg::SPEED_STEP;
    offset_dn = offset - scope_ctrl_pkg::SPEED_STEP;
    if (offset_up > scope_ctrl_pkg::SPEED_LIMIT)
      offset_up = scope_ctrl_pkg::SPEED_LIMIT;
    if (offset_dn < -scope_ctrl_pkg::SPEED_LIMIT)
      offset_dn = -scope_ctrl_pkg::SPEED_LIMIT;
  end

  // ==============================
  // Offset register
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      offset <= '0;
    else
    begin
      case (cmd)
        scope_ctrl_pkg::CMD_UP:    offset <= offset_up;
        scope_ctrl_pkg::CMD_DOWN:  offset <= offset_dn;
        scope_ctrl_pkg::CMD_RESET: offset <= '0;
        default:                   offset <= offset;
      endcase
    end
  end

  // Period follows the offset one cycle later
  // Never wraps, the limit is below the default
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      period <= scope_ctrl_pkg::DEFAULT_PERIOD;
    else
      period <= scope_ctrl_pkg::DEFAULT_PERIOD + $unsigned(offset);
  end

endmodule

//--- logic/tone_gen.sv
`timescale 1ns/1ps

module tone_gen (
  input  logic                            CLK_50M,
  input  logic                            rst_n,
  input  logic [2:0]                      note_sel,
  input  logic                            tone_en,
  output logic [organ_pkg::SAMPLE_W-1:0]  audio_sample
);

  logic [2:0] note_meta;
  logic [2:0] note_sync;
  logic       en_meta;
  logic       en_sync;

  organ_pkg::note_e note;
  organ_pkg::note_e note_q;

  logic [organ_pkg::HALF_PERIOD_W-1:0] half_period;
  logic [organ_pkg::HALF_PERIOD_W-1:0] div_cnt;
  logic                                phase;

  // ==============================
  // Switch synchronisers
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      note_meta <= '0;
      note_sync <= '0;
      en_meta   <= 1'b0;
      en_sync   <= 1'b0;
    end
    else
    begin
      note_meta <= note_sel;
      note_sync <= note_meta;
      en_meta   <= tone_en;
      en_sync   <= en_meta;
    end
  end

  assign note        = organ_pkg::note_e'(note_sync);
  assign half_period = organ_pkg::NOTE_HALF_PERIOD[note];

  // ==============================
  // Pitch divider
  // ==============================

  // Counts 0 to half_period, so each level is half_period + 1 cycles
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      note_q  <= organ_pkg::C5;
      div_cnt <= '0;
      phase   <= 1'b0;
    end
    else
    begin
      note_q <= note;
      if (note != note_q)
        div_cnt <= '0;
      else if (div_cnt >= half_period)
      begin
        div_cnt <= '0;
        phase   <= ~phase;
      end
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

  // Output sample, silent when disabled
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      audio_sample <= organ_pkg::SAMPLE_ZERO;
    else if (!en_sync)
      audio_sample <= organ_pkg::SAMPLE_ZERO;
    else if (phase)
      audio_sample <= organ_pkg::SAMPLE_HIGH;
    else
      audio_sample <= organ_pkg::SAMPLE_LOW;
  end

endmodule

//--- verification/basic_organ_tb.sv
`timescale 1ns/1ps

module basic_organ_tb;

  localparam int CLK_PERIOD = 20;
  localparam int TICK_DIV = 50;
  localparam int WINDOW_CYCLES = scope_ctrl_pkg::REPEAT_TICKS * TICK_DIV;
  localparam int REFRESH_CYCLES = scope_ctrl_pkg::REFRESH_TICKS * TICK_DIV;
  localparam int REFRESH_WAIT = REFRESH_CYCLES + 2;
  localparam int STEP = 100;
  localparam int LIMIT = 12000;
  localparam int DEFAULT_PERIOD = 12499;
  localparam int MIN_PERIOD = DEFAULT_PERIOD - LIMIT;
  localparam int MAX_PERIOD = DEFAULT_PERIOD + LIMIT;

  // Reference tables
  localparam int HALF_PERIOD [8] = '{47801, 42589, 37936, 35817, 31928, 28409, 25329, 23901};
  localparam logic [6:0] GLYPH [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
    7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  // ==============================
  // Run length budget, in cycles
  // ==============================
  localparam longint PITCH_BUDGET = 3 * (HALF_PERIOD[0] + 1) + 100;
  localparam longint UP_BUDGET = 7 * WINDOW_CYCLES;
  localparam longint DOWN_BUDGET = (LIMIT / STEP + 13) * WINDOW_CYCLES + REFRESH_WAIT;
  localparam longint SWEEP_BUDGET = (2 * LIMIT / STEP + 5) * WINDOW_CYCLES + REFRESH_WAIT;
  localparam longint RESET_BUDGET = 4 * WINDOW_CYCLES + REFRESH_WAIT + 200;
  localparam longint TOTAL_CYCLES = PITCH_BUDGET + UP_BUDGET + DOWN_BUDGET
                                    + SWEEP_BUDGET + RESET_BUDGET;
  localparam longint WATCHDOG_NS = (TOTAL_CYCLES + TOTAL_CYCLES / 10) * CLK_PERIOD;

  logic        CLK_50M;
  logic        rst_n;
  logic [2:0]  key_n;
  logic [2:0]  note_sel;
  logic        tone_en;
  logic [7:0]  audio_sample;
  logic [15:0] scope_period;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;

  integer      seed = 60590;
  int          error_count = 0;
  longint      cycle_cnt = 0;
  longint      last_hex_change = -1;
  logic [41:0] hex_last;

  basic_organ #(
    .tick_div (TICK_DIV)
  ) dut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .key_n        (key_n),
    .note_sel     (note_sel),
    .tone_en      (tone_en),
    .audio_sample (audio_sample),
    .scope_period (scope_period),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  initial CLK_50M = 1'b0;
  always #(CLK_PERIOD / 2) CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
    cycle_cnt <= cycle_cnt + 1;

  task automatic stop_with_error(input string msg);
    error_count++;
    $display("Error at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  // Advance n cycles, ending just after a rising edge
  task automatic step_cycles(input int n);
    repeat (n)
    begin
      @(posedge CLK_50M);
      #1;
    end
  endtask

  function automatic bit display_shows(input logic [15:0] v);
    return (hex0 == GLYPH[v[3:0]]) && (hex1 == GLYPH[v[7:4]]) && (hex2 == GLYPH[v[11:8]])
           && (hex3 == GLYPH[v[15:12]]) && (hex4 == GLYPH[0]) && (hex5 == GLYPH[0]);
  endfunction

  // Wait for one period change, check its size and its distance to the last one
  task automatic wait_step(input int dir, inout longint last_cycle);
    logic [15:0] prev;
    prev = scope_period;
    while (scope_period == prev)
      step_cycles(1);
    assert (int'(scope_period) - int'(prev) == dir * STEP)
    else stop_with_error($sformatf("period stepped %0d to %0d", prev, scope_period));
    if (last_cycle >= 0)
    begin
      assert (cycle_cnt - last_cycle == WINDOW_CYCLES)
      else stop_with_error($sformatf("steps %0d cycles apart", cycle_cnt - last_cycle));
    end
    last_cycle = cycle_cnt;
  endtask

  task automatic hold_steady(input int value, input int cycles);
    repeat (cycles)
    begin
      step_cycles(1);
      assert (scope_period == value)
      else stop_with_error($sformatf("period %0d, expected %0d", scope_period, value));
    end
  endtask

  // Digits must show the period at most one refresh after it settled
  task automatic check_display(input longint settled);
    bit  seen;
    seen = display_shows(scope_period);
    while (!seen && cycle_cnt - settled < REFRESH_WAIT)
    begin
      step_cycles(1);
      seen = display_shows(scope_period);
    end
    assert (seen)
    else stop_with_error($sformatf("display does not show period %h", scope_period));
  endtask

  // Digits only change a whole number of refresh intervals apart
  always @(posedge CLK_50M)
  begin
    #1;
    if (!rst_n)
      last_hex_change = -1;
    else if ({hex5, hex4, hex3, hex2, hex1, hex0} != hex_last)
    begin
      if (last_hex_change >= 0)
      begin
        assert ((cycle_cnt - last_hex_change) % REFRESH_CYCLES == 0)
        else stop_with_error("hex digits changed between refreshes");
      end
      last_hex_change = cycle_cnt;
    end
    hex_last = {hex5, hex4, hex3, hex2, hex1, hex0};
  end

  audio_levels: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (audio_sample == 8'h00) || (audio_sample == 8'h7F) || (audio_sample == 8'h80))
  else stop_with_error("audio sample outside the square-wave levels");

  period_bounds: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (scope_period >= MIN_PERIOD) && (scope_period <= MAX_PERIOD))
  else stop_with_error("scope period outside its limits");

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish in the expected time");
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial
  begin
    int          note_code;
    int          hold;
    longint      last_cycle;
    longint      start;
    logic [7:0]  level;

    rst_n    = 1'b0;
    key_n    = 3'b111;
    note_sel = 3'd0;
    tone_en  = 1'b0;
    step_cycles(8);
    rst_n = 1'b1;

    // ==============================
    // After reset
    // ==============================
    step_cycles(1);
    assert (audio_sample == 8'h00) else stop_with_error("audio sample not 0 after reset");
    assert (scope_period == DEFAULT_PERIOD) else stop_with_error("period wrong after reset");
    assert (display_shows(16'h0000)) else stop_with_error("digits not 0 after reset");

    // ==============================
    // Pitch
    // ==============================
    note_code = $unsigned($random(seed)) % 8;
    note_sel  = note_code[2:0];
    tone_en   = 1'b1;
    while (audio_sample == 8'h00)
      step_cycles(1);
    // Skip the first, possibly partial level
    level = audio_sample;
    while (audio_sample == level)
      step_cycles(1);
    repeat (2)
    begin
      level = audio_sample;
      start = cycle_cnt;
      while (audio_sample == level)
        step_cycles(1);
      assert (cycle_cnt - start == HALF_PERIOD[note_code] + 1)
      else stop_with_error($sformatf("note %0d level lasted %0d cycles", note_code,
                                     cycle_cnt - start));
      assert (audio_sample == ((level == 8'h7F) ? 8'h80 : 8'h7F))
      else stop_with_error($sformatf("sample %h after level %h", audio_sample, level));
    end
    tone_en = 1'b0;
    step_cycles(3);
    assert (audio_sample == 8'h00) else stop_with_error("audio not silent after disable");

    // Up key, a few steps
    hold = 2 + $unsigned($random(seed)) % 4;
    last_cycle = -1;
    key_n = 3'b110;
    repeat (hold)
      wait_step(1, last_cycle);
    key_n = 3'b111;
    step_cycles(5);

    // Down key to the lower limit
    last_cycle = -1;
    key_n = 3'b101;
    while (scope_period != MIN_PERIOD)
      wait_step(-1, last_cycle);
    hold_steady(MIN_PERIOD, 3 * WINDOW_CYCLES);
    check_display(last_cycle);
    key_n = 3'b111;
    step_cycles(5);

    // Up key to the upper limit
    last_cycle = -1;
    key_n = 3'b110;
    while (scope_period != MAX_PERIOD)
      wait_step(1, last_cycle);
    hold_steady(MAX_PERIOD, 3 * WINDOW_CYCLES);
    check_display(last_cycle);
    key_n = 3'b111;
    step_cycles(5);

    // ==============================
    // Reset key, with up held too
    // ==============================
    key_n = 3'b010;
    step_cycles(4);
    assert (scope_period == DEFAULT_PERIOD) else stop_with_error("reset key too slow");
    start = cycle_cnt;
    hold = WINDOW_CYCLES + $unsigned($random(seed)) % (2 * WINDOW_CYCLES);
    hold_steady(DEFAULT_PERIOD, hold);
    key_n = 3'b111;
    hold_steady(DEFAULT_PERIOD, 10);
    check_display(start);

    if (error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
